//--- prefetch_buffer.f
common/fetch_bus_pkg.sv
common/prefetch_pkg.sv
prefetch/fetch_fifo.sv
prefetch/fetch_fsm.sv
prefetch/prefetch_buffer.sv
bench/tb_clock_gen.sv
bench/tb_instr_mem.sv
bench/tb_prefetch_buffer.sv

//--- run_sim.sh
#!/bin/sh
# builds the prefetch testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_prefetch_buffer \
  -f prefetch_buffer.f -o sim_prefetch_buffer

status=0
./obj_dir/sim_prefetch_buffer > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

//--- bench/tb_prefetch_buffer.sv
// fixed-seed random stream; outputs are sampled on the falling edge and driven on the rising one
`default_nettype none
`timescale 1ns/1ps

module tb_prefetch_buffer;

  localparam logic [31:0] SEED = 32'h38e3bf60;
  // five tests take about 1500 cycles at the slowest memory delays
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MODE_STEADY    = 0;
  localparam int MODE_BRANCHY   = 1;
  localparam int MODE_PRESSURE  = 2;

  logic                 clk;
  logic                 rst_n;
  logic                 req = 1'b0;
  logic                 branch = 1'b0;
  fetch_bus_pkg::addr_t branch_addr = '0;
  logic                 ready = 1'b0;
  logic                 valid;
  fetch_bus_pkg::word_t rdata;
  fetch_bus_pkg::addr_t out_addr;
  logic                 mem_req;
  logic                 mem_gnt;
  fetch_bus_pkg::addr_t mem_addr;
  fetch_bus_pkg::word_t mem_rdata;
  logic                 mem_rvalid;
  logic                 busy;

  integer seed = SEED;
  int     mode = MODE_STEADY;
  int     cycles = 0;
  // one-shot branch requests from the test sequence to the driver
  int     kick_req = 0;
  int     kick_done = 0;
  logic   kick_unaligned = 1'b0;
  int     branch_cnt = 0;

  // reference model and score
  fetch_bus_pkg::addr_t exp_pc = '0;
  fetch_bus_pkg::word_t exp_instr;
  logic                 exp_full;
  logic                 seen_branch = 1'b0;
  logic                 hold_q = 1'b0;
  fetch_bus_pkg::addr_t held_addr;
  fetch_bus_pkg::word_t held_instr;
  logic                 held_full;
  int                   consumed = 0;
  int                   checks = 0;
  int                   errors = 0;
  int                   err_base;
  int                   cons_base;

  // memory bus as seen from outside
  // a granted word not yet returned
  logic                 pend_q = 1'b0;
  // a request left waiting for its grant
  logic                 wait_q = 1'b0;
  fetch_bus_pkg::addr_t wait_addr = '0;

  tb_clock_gen clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  tb_instr_mem #(.SEED(SEED)) mem (
    .clk(clk), .rst_n(rst_n), .req_i(mem_req), .addr_i(mem_addr),
    .gnt_o(mem_gnt), .rdata_o(mem_rdata), .rvalid_o(mem_rvalid)
  );

  prefetch_buffer dut (
    .clk(clk), .rst_n(rst_n), .req_i(req), .branch_i(branch), .addr_i(branch_addr),
    .ready_i(ready), .valid_o(valid), .rdata_o(rdata), .addr_o(out_addr),
    .instr_req_o(mem_req), .instr_gnt_i(mem_gnt), .instr_addr_o(mem_addr),
    .instr_rdata_i(mem_rdata), .instr_rvalid_i(mem_rvalid), .busy_o(busy)
  );

  ////////////////////////////////////////
  // memory image and helpers
  ////////////////////////////////////////

  // same hash as the memory model fills itself with
  function automatic fetch_bus_pkg::word_t word_at(input fetch_bus_pkg::addr_t a);
    logic [31:0] x;
    x = {2'b00, a[31:2]} * 32'h9e3779b1;
    x = x ^ (x >> 15);
    x = x * 32'h85ebca6b;
    x = x ^ (x >> 13);
    return x;
  endfunction

  function automatic logic [15:0] half_at(input fetch_bus_pkg::addr_t a);
    fetch_bus_pkg::word_t w;
    w = word_at(a);
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // halfword-aligned target in the low 64 KiB
  function automatic fetch_bus_pkg::addr_t pick_target(input logic unaligned);
    logic [31:0] r;
    r = $random(seed);
    return {16'h0, r[15:2], unaligned, 1'b0};
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input fetch_bus_pkg::addr_t got, input fetch_bus_pkg::addr_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // compressed instructions only own their lower halfword
  task automatic check_instr(input fetch_bus_pkg::word_t got, input fetch_bus_pkg::word_t exp,
                             input logic full, input string what);
    checks++;
    if (full ? (got !== exp) : (got[15:0] !== exp[15:0])) begin
      errors++;
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // driver
  ////////////////////////////////////////

  always @(posedge clk) begin
    branch <= 1'b0;
    if (rst_n) begin
      // ready low about a third of the time and req with short gaps
      ready <= (mode != MODE_PRESSURE) || (rand_below(3) != 0);
      req   <= (mode != MODE_PRESSURE) || (rand_below(12) != 0);
      if (kick_req != kick_done) begin
        branch      <= 1'b1;
        branch_addr <= pick_target(kick_unaligned);
        kick_done   = kick_req;
        branch_cnt  <= branch_cnt + 1;
      end else if ((mode == MODE_BRANCHY && rand_below(6) == 0) ||
                   (mode == MODE_PRESSURE && rand_below(40) == 0)) begin
        branch      <= 1'b1;
        branch_addr <= pick_target(rand_below(2) == 1);
        branch_cnt  <= branch_cnt + 1;
      end
    end
  end

  ////////////////////////////////////////
  // monitor and reference model
  ////////////////////////////////////////

  // falling edge sees the values the DUT takes at the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (!seen_branch && !branch) begin
        check_flag(valid, 1'b0, "valid before first branch");
        check_flag(mem_req, 1'b0, "memory request before first branch");
      end
      // busy covers a raised request and a word still owed by memory
      check_flag(busy, mem_req | pend_q, "busy");
      // one request in flight, the next may only go out with the rvalid
      if (pend_q && !mem_rvalid) begin
        check_flag(mem_req, 1'b0, "request while a word is outstanding");
      end
      if (wait_q && !branch) begin
        check_flag(mem_req, 1'b1, "request dropped before grant");
        check_addr(mem_addr, wait_addr, "request addr changed before grant");
      end
      // target goes out at once unless the old word is still owed
      if (branch && (!pend_q || mem_rvalid)) begin
        check_flag(mem_req, 1'b1, "no request in branch cycle");
        check_addr(mem_addr, branch_addr, "branch target on memory bus");
      end
      if (hold_q && !branch) begin
        check_flag(valid, 1'b1, "valid dropped while stalled");
        check_addr(out_addr, held_addr, "addr changed while stalled");
        check_instr(rdata, held_instr, held_full, "instr changed while stalled");
      end
      if (valid && ready) begin
        // pc model builds the instruction from two halfwords of the image
        exp_instr = {half_at(exp_pc + 32'd2), half_at(exp_pc)};
        exp_full  = exp_instr[1:0] == fetch_bus_pkg::FULL_LEN_CODE;
        check_addr(out_addr, exp_pc, "consumed addr");
        check_instr(rdata, exp_instr, exp_full, "consumed instr");
        exp_pc   = exp_pc + (exp_full ? 32'd4 : 32'd2);
        consumed <= consumed + 1;
      end
      if (branch) begin
        exp_pc      = branch_addr;
        seen_branch = 1'b1;
      end
      hold_q     = valid && !ready && !branch;
      held_addr  = out_addr;
      held_instr = rdata;
      held_full  = rdata[1:0] == fetch_bus_pkg::FULL_LEN_CODE;
      // bus state for the next cycle
      if (mem_req && mem_gnt) begin
        pend_q = 1'b1;
      end else if (mem_rvalid) begin
        pend_q = 1'b0;
      end
      wait_q    = mem_req && !mem_gnt;
      wait_addr = mem_addr;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  task automatic branch_to(input logic unaligned);
    @(negedge clk);
    kick_unaligned = unaligned;
    kick_req       = kick_req + 1;
  endtask

  task automatic wait_consumed(input int n);
    int target;
    @(posedge clk);
    target = consumed + n;
    while (consumed < target) @(posedge clk);
  endtask

  task automatic wait_branches(input int n);
    int target;
    @(posedge clk);
    target = branch_cnt + n;
    while (branch_cnt < target) @(posedge clk);
  endtask

  task automatic start_test();
    err_base  = errors;
    cons_base = consumed;
  endtask

  task automatic report(input string name);
    $display("test %-16s done: %0d instructions, %0d errors", name,
             consumed - cons_base, errors - err_base);
  endtask

  initial begin
    @(posedge rst_n);
    start_test();
    repeat (12) @(posedge clk);
    report("reset idle");

    start_test();
    branch_to(1'b0);
    wait_consumed(60);
    report("aligned stream");

    start_test();
    branch_to(1'b1);
    wait_consumed(60);
    report("unaligned stream");

    // branches land in every FSM state including grant and data waits
    start_test();
    mode = MODE_BRANCHY;
    wait_branches(25);
    mode = MODE_STEADY;
    wait_consumed(20);
    report("random branches");

    start_test();
    mode = MODE_PRESSURE;
    branch_to(1'b1);
    wait_consumed(100);
    mode = MODE_STEADY;
    report("back-pressure");

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_instr_mem.sv
// behavioural instruction memory; grant after 0..3 cycles, rvalid 1..3 cycles after it, one request in flight
`default_nettype none
`timescale 1ns/1ps

module tb_instr_mem #(
  parameter logic [31:0] SEED = 32'h38e3bf60
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_i,
  input  wire fetch_bus_pkg::addr_t  addr_i,
  output      logic                  gnt_o,
  output      fetch_bus_pkg::word_t  rdata_o,
  output      logic                  rvalid_o
);

  integer               seed = SEED;
  // cycles the current request has waited, and how long it must wait
  int unsigned          gnt_wait;
  int unsigned          gnt_delay;
  // one accepted request, answered when rv_cnt runs out
  logic                 pend;
  logic [1:0]           rv_cnt;
  fetch_bus_pkg::addr_t addr_q;

  // contents from a mixing hash of the word address, so every halfword has random length bits
  function automatic fetch_bus_pkg::word_t word_at(input fetch_bus_pkg::addr_t a);
    logic [31:0] x;
    x = {2'b00, a[31:2]} * 32'h9e3779b1;
    x = x ^ (x >> 15);
    x = x * 32'h85ebca6b;
    x = x ^ (x >> 13);
    return x;
  endfunction

  ////////////////////////////////////////
  // bus outputs
  ////////////////////////////////////////

  // zero delay grants in the same cycle the request appears
  assign gnt_o    = req_i && (gnt_wait >= gnt_delay);
  assign rvalid_o = pend && (rv_cnt == 2'd0);
  // low two address bits are ignored
  assign rdata_o  = word_at(addr_q);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait  <= 0;
      gnt_delay <= 0;
      pend      <= 1'b0;
      rv_cnt    <= 2'd0;
      addr_q    <= '0;
    end else if (req_i && gnt_o) begin
      // accepted; a grant in the rvalid cycle starts the next answer at once
      gnt_wait  <= 0;
      gnt_delay <= $unsigned($random(seed)) % 4;
      pend      <= 1'b1;
      rv_cnt    <= 2'($unsigned($random(seed)) % 3);
      addr_q    <= addr_i;
    end else begin
      if (req_i) begin
        gnt_wait <= gnt_wait + 1;
      end
      if (rvalid_o) begin
        pend <= 1'b0;
      end else if (pend) begin
        rv_cnt <= rv_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// free-running clock with a 40 ns period; reset is released on a rising edge after 8 cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // half period per toggle
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held low, then released with a non-blocking write like the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- prefetch/prefetch_buffer.sv
// addr_i must be halfword aligned; the instruction is taken when valid_o and ready_i are both high
`default_nettype none
`timescale 1ns/1ps

module prefetch_buffer (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // core control
  input  wire logic                  req_i,
  input  wire logic                  branch_i,
  input  wire fetch_bus_pkg::addr_t  addr_i,

  // instruction out to the core
  input  wire logic                  ready_i,
  output      logic                  valid_o,
  output      fetch_bus_pkg::word_t  rdata_o,
  output      fetch_bus_pkg::addr_t  addr_o,

  // instruction memory
  output      logic                  instr_req_o,
  input  wire logic                  instr_gnt_i,
  output      fetch_bus_pkg::addr_t  instr_addr_o,
  input  wire fetch_bus_pkg::word_t  instr_rdata_i,
  input  wire logic                  instr_rvalid_i,

  output      logic                  busy_o
);

  // FSM to FIFO handoff
  logic                 fifo_push;
  logic                 fifo_ready;
  fetch_bus_pkg::addr_t fifo_addr;

  // memory requests, abort on branch
  fetch_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (addr_i),
    .fifo_ready_i   (fifo_ready),
    .fifo_push_o    (fifo_push),
    .fifo_addr_o    (fifo_addr),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  // word storage and 16/32-bit aligner, flushed by the branch pulse
  fetch_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (branch_i),
    .in_addr_i   (fifo_addr),
    .in_rdata_i  (instr_rdata_i),
    .in_valid_i  (fifo_push),
    .in_ready_o  (fifo_ready),
    .out_valid_o (valid_o),
    .out_ready_i (ready_i),
    .out_rdata_o (rdata_o),
    .out_addr_o  (addr_o)
  );

endmodule

`default_nettype wire

//--- prefetch/fetch_fsm.sv
// one request in flight; a branch always requests its target, sequential fetch needs req_i and a prior branch
`default_nettype none
`timescale 1ns/1ps

module fetch_fsm (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // core control
  input  wire logic                  req_i,
  input  wire logic                  branch_i,
  input  wire fetch_bus_pkg::addr_t  branch_addr_i,

  // towards the fetch FIFO
  input  wire logic                  fifo_ready_i,
  output      logic                  fifo_push_o,
  output      fetch_bus_pkg::addr_t  fifo_addr_o,

  // instruction memory
  output      logic                  instr_req_o,
  input  wire logic                  instr_gnt_i,
  output      fetch_bus_pkg::addr_t  instr_addr_o,
  input  wire logic                  instr_rvalid_i,

  output      logic                  busy_o
);

  prefetch_pkg::fetch_state_e state_q;
  prefetch_pkg::fetch_state_e state_d;

  // address of the latest accepted or pending request
  fetch_bus_pkg::addr_t fetch_addr_q;
  fetch_bus_pkg::addr_t next_addr;
  logic                 addr_load;

  // set by the first branch, sequential fetch has no start point before it
  logic stream_on_q;
  logic seq_ok;

  ////////////////////////////////////////
  // address and status
  ////////////////////////////////////////

  // sequential fetch steps whole words
  assign next_addr = {fetch_addr_q[31:2], 2'b00} + fetch_bus_pkg::WORD_BYTES;

  // the returning word always belongs to fetch_addr_q
  assign fifo_addr_o = fetch_addr_q;

  // room for one more word, and the core still wants instructions
  assign seq_ok = req_i & fifo_ready_i & stream_on_q;

  assign busy_o = (state_q != prefetch_pkg::IDLE) | instr_req_o;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = fetch_addr_q;
    addr_load    = 1'b0;
    fifo_push_o  = 1'b0;

    unique case (state_q)
      prefetch_pkg::IDLE: begin
        instr_addr_o = branch_i ? branch_addr_i : next_addr;
        // a branch fetches its target even with the FIFO full, the FIFO is cleared
        if (branch_i || seq_ok) begin
          instr_req_o = 1'b1;
          addr_load   = 1'b1;
          state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
        end
      end

      prefetch_pkg::WAIT_GNT: begin
        // hold the request, a branch may swap the address before the grant
        instr_req_o = 1'b1;
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
          addr_load    = 1'b1;
        end
        if (instr_gnt_i) begin
          state_d = prefetch_pkg::WAIT_RVALID;
        end
      end

      prefetch_pkg::WAIT_RVALID: begin
        if (branch_i) begin
          // whatever comes back now is stale
          addr_load    = 1'b1;
          instr_addr_o = branch_addr_i;
          if (instr_rvalid_i) begin
            // slot is free this cycle, go for the target at once
            instr_req_o = 1'b1;
            state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
          end else begin
            state_d = prefetch_pkg::WAIT_ABORTED;
          end
        end else if (instr_rvalid_i) begin
          fifo_push_o = 1'b1;
          // back-to-back: next word requested in the rvalid cycle
          if (seq_ok) begin
            instr_req_o  = 1'b1;
            instr_addr_o = next_addr;
            addr_load    = 1'b1;
            state_d      = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
          end else begin
            state_d = prefetch_pkg::IDLE;
          end
        end
      end

      prefetch_pkg::WAIT_ABORTED: begin
        // fetch_addr_q already holds the target, a later branch replaces it
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
          addr_load    = 1'b1;
        end
        // stale word is dropped, then the target goes out
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
        end
      end

      default: begin
        state_d = prefetch_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= prefetch_pkg::IDLE;
      fetch_addr_q <= '0;
      stream_on_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (addr_load) begin
        fetch_addr_q <= instr_addr_o;
      end
      if (branch_i) begin
        stream_on_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- prefetch/fetch_fifo.sv
// in_valid_i must never hit a full FIFO; clear_i empties it for the next cycle and masks out_valid_o
`default_nettype none
`timescale 1ns/1ps

module fetch_fifo (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // flush on branch
  input  wire logic                  clear_i,

  // word side, from the fetch FSM
  input  wire fetch_bus_pkg::addr_t  in_addr_i,
  input  wire fetch_bus_pkg::word_t  in_rdata_i,
  input  wire logic                  in_valid_i,
  output      logic                  in_ready_o,

  // instruction side, towards the core
  output      logic                  out_valid_o,
  input  wire logic                  out_ready_i,
  output      fetch_bus_pkg::word_t  out_rdata_o,
  output      fetch_bus_pkg::addr_t  out_addr_o
);

  // stored entries, index 0 is the head
  fetch_bus_pkg::addr_t  addr_q   [prefetch_pkg::FIFO_DEPTH];
  fetch_bus_pkg::word_t  rdata_q  [prefetch_pkg::FIFO_DEPTH];
  logic [prefetch_pkg::FIFO_DEPTH-1:0] valid_q;

  // entries with the incoming word already placed
  fetch_bus_pkg::addr_t  addr_int  [prefetch_pkg::FIFO_DEPTH];
  fetch_bus_pkg::word_t  rdata_int [prefetch_pkg::FIFO_DEPTH];
  logic [prefetch_pkg::FIFO_DEPTH-1:0] valid_int;

  // entries after consumption
  fetch_bus_pkg::addr_t  addr_n    [prefetch_pkg::FIFO_DEPTH];
  fetch_bus_pkg::word_t  rdata_n   [prefetch_pkg::FIFO_DEPTH];
  logic [prefetch_pkg::FIFO_DEPTH-1:0] valid_n;

  // first free slot
  prefetch_pkg::fifo_idx_t wr_idx;
  logic                    wr_found;

  // aligner view of the head
  fetch_bus_pkg::word_t     head_word;
  fetch_bus_pkg::word_t     next_word;
  fetch_bus_pkg::len_code_t len_code;
  fetch_bus_pkg::addr_t     head_next_addr;
  logic                     unaligned;
  logic                     full_len;
  logic                     instr_valid;
  logic                     consume;
  logic                     pop;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  // keep one entry spare for the word that may still be in flight
  assign in_ready_o = ~valid_q[prefetch_pkg::FIFO_DEPTH-2];

  // lowest free entry wins, so scan from the top down
  always_comb begin
    wr_idx   = '0;
    wr_found = 1'b0;
    for (int i = prefetch_pkg::FIFO_DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        wr_idx   = prefetch_pkg::fifo_idx_t'(i);
        wr_found = 1'b1;
      end
    end
  end

  // an empty FIFO hands the new word straight to entry 0, giving the bypass
  always_comb begin
    addr_int  = addr_q;
    rdata_int = rdata_q;
    valid_int = valid_q;
    if (in_valid_i && wr_found) begin
      addr_int[wr_idx]  = in_addr_i;
      rdata_int[wr_idx] = in_rdata_i;
      valid_int[wr_idx] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // aligner
  ////////////////////////////////////////

  assign head_word = rdata_int[0];
  assign next_word = rdata_int[1];
  // bit 1 of the head address says which halfword the instruction starts in
  assign unaligned = addr_int[0][1];

  assign len_code = unaligned ? head_word[17:16] : head_word[1:0];
  assign full_len = fetch_bus_pkg::is_full_len(len_code);

  always_comb begin
    if (unaligned) begin
      // upper half of head, then lower half of the next word
      out_rdata_o = {next_word[15:0], head_word[31:16]};
      // a straddling 32-bit instruction waits for both words
      instr_valid = full_len ? (valid_int[0] & valid_int[1]) : valid_int[0];
    end else begin
      out_rdata_o = head_word;
      instr_valid = valid_int[0];
    end
  end

  // nothing leaves in a flush cycle, the content is stale
  assign out_valid_o = instr_valid & ~clear_i;
  assign out_addr_o  = addr_int[0];

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  assign consume = out_valid_o & out_ready_i;
  // head word is done once its upper halfword has been used
  assign pop     = unaligned | full_len;

  assign head_next_addr = {addr_int[0][31:2], 2'b00} + fetch_bus_pkg::WORD_BYTES;

  always_comb begin
    addr_n  = addr_int;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (consume) begin
      if (pop) begin
        // shift everything down one entry
        for (int i = 0; i < prefetch_pkg::FIFO_DEPTH - 1; i++) begin
          addr_n[i]  = addr_int[i+1];
          rdata_n[i] = rdata_int[i+1];
        end
        valid_n = valid_int >> 1;
        // a straddling instruction used the lower half of the next word
        addr_n[0] = {head_next_addr[31:2], unaligned & full_len, 1'b0};
      end else begin
        // aligned compressed, stay on this word at its upper half
        addr_n[0] = {addr_int[0][31:2], 2'b10};
      end
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  // payload, only meaningful where valid_q is set
  always_ff @(posedge clk) begin
    addr_q  <= addr_n;
    rdata_q <= rdata_n;
  end

endmodule

`default_nettype wire

//--- common/prefetch_pkg.sv
// prefetch internals; FIFO_DEPTH below 3 breaks the one-in-flight back-pressure margin
`default_nettype none

package prefetch_pkg;

  ////////////////////////////////////////
  // fetch FIFO sizing
  ////////////////////////////////////////

  // word entries, entry 0 is the output head
  localparam int unsigned FIFO_DEPTH = 3;

  // index of one FIFO entry
  typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_idx_t;

  ////////////////////////////////////////
  // fetch FSM states
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    // nothing outstanding
    IDLE,
    // request raised, grant still missing
    WAIT_GNT,
    // granted, data still missing
    WAIT_RVALID,
    // granted but a branch came, returning word is dropped
    WAIT_ABORTED
  } fetch_state_e;

endpackage

`default_nettype wire

//--- common/fetch_bus_pkg.sv
// assumes a 32-bit byte-addressed instruction memory that returns whole words; no bus errors
`default_nettype none

package fetch_bus_pkg;

  ////////////////////////////////////////
  // memory-side widths
  ////////////////////////////////////////

  // byte address, low two bits are ignored by the memory
  typedef logic [31:0] addr_t;

  // one memory word or one (possibly joined) instruction
  typedef logic [31:0] word_t;

  // low two bits of an instruction, they give its length
  typedef logic [1:0] len_code_t;

  // byte step between sequential word fetches
  localparam addr_t WORD_BYTES = 32'd4;

  // length code of a full 32-bit instruction
  // any other code is a 16-bit compressed one
  localparam len_code_t FULL_LEN_CODE = 2'b11;

  ////////////////////////////////////////
  // instruction length rule
  ////////////////////////////////////////

  function automatic logic is_full_len(input len_code_t code);
    return code == FULL_LEN_CODE;
  endfunction

endpackage

`default_nettype wire
